/* stream_merge_pkg.sv */
/*
  Shared widths, APB register offsets and control bit positions
  Data word and APB address and data types
*/

package stream_merge_pkg;

  // **************************************************
  // Stream word
  // **************************************************

  localparam int WORD_W = 16;

  // Upper bits of a word hold the index of the source that sent it
  localparam int SRC_ID_W = 4;

  typedef logic [WORD_W-1:0] word_t;

  // **************************************************
  // APB register map
  // **************************************************

  localparam int APB_ADDR_W = 4;
  localparam int APB_DATA_W = 32;

  typedef logic [APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [APB_DATA_W-1:0] apb_data_t;

  localparam apb_addr_t REG_DATA   = 4'h0;
  localparam apb_addr_t REG_STATUS = 4'h4;
  localparam apb_addr_t REG_CTRL   = 4'h8;

  // Control register fields
  localparam int CTRL_ENABLE_BIT = 0;
  localparam int CTRL_CLEAR_BIT  = 1;

  // Head word last flag in the status register
  localparam int STATUS_LAST_BIT = 8;

endpackage

/* packet_granter.sv */
/*
  Packet-locked one-hot grant register
  Fixed-priority choice of the next grant from valid and hint lists
*/

`timescale 1ns/1ps

module packet_granter #(
  parameter int NUM_SRC = 4
) (
  input  logic               clk,
  input  logic               rstnn,
  input  logic               clear,
  input  logic               enable,
  input  logic [NUM_SRC-1:0] cand_valid,
  input  logic [NUM_SRC-1:0] cand_hint,
  input  logic [NUM_SRC-1:0] cand_last,
  input  logic               granted_ready,
  output logic [NUM_SRC-1:0] grant,
  output logic               granted_valid,
  output logic               granted_last
);

  logic [NUM_SRC-1:0] first_valid;
  logic [NUM_SRC-1:0] first_hint;
  logic [NUM_SRC-1:0] next_grant;
  logic [NUM_SRC-1:0] others;
  logic               any_other;
  logic               last_xfer;
  logic               switch_ok;

  // Isolates the lowest set bit of a vector
  function automatic logic [NUM_SRC-1:0] lowest_one(input logic [NUM_SRC-1:0] vec);
    lowest_one = vec & (~vec + {{(NUM_SRC-1){1'b0}}, 1'b1});
  endfunction

  // **************************************************
  // Granted source view
  // **************************************************

  assign granted_valid = |(cand_valid & grant);
  assign granted_last  = |(cand_last & grant);

  // Final word of the locked packet is accepted this cycle
  assign last_xfer = granted_valid & granted_ready & granted_last;

  // Any other source that wants the output
  assign others    = (cand_valid | cand_hint) & ~grant;
  assign any_other = |others;

  // Hold the grant inside a packet
  // Release it after the last word or while the owner is idle
  assign switch_ok = granted_valid ? (last_xfer & any_other) : any_other;

  // **************************************************
  // Next grant
  // **************************************************

  assign first_valid = lowest_one(cand_valid);
  assign first_hint  = lowest_one(cand_hint);

  // Valid sources win over hinting ones
  assign next_grant = (cand_valid != '0) ? first_valid : first_hint;

  // One-hot grant that returns to source 0 on reset and clear
  always_ff @(posedge clk or negedge rstnn)
  begin
    if (!rstnn)
    begin
      grant <= {{(NUM_SRC-1){1'b0}}, 1'b1};
    end
    else if (clear)
    begin
      grant <= {{(NUM_SRC-1){1'b0}}, 1'b1};
    end
    else if (enable && switch_ok)
    begin
      grant <= next_grant;
    end
  end

endmodule

/* stream_merger.sv */
/*
  Packet merger of NUM_SRC source streams into one stream
  Grant-gated ready and one-hot AND-OR data mux
*/

`timescale 1ns/1ps

module stream_merger #(
  parameter int NUM_SRC = 4
) (
  input  logic                                      clk,
  input  logic                                      rstnn,
  input  logic                                      clear,
  input  logic                                      enable,
  input  logic [NUM_SRC-1:0]                        src_valid,
  input  logic [NUM_SRC-1:0]                        src_hint,
  input  logic [NUM_SRC-1:0]                        src_last,
  input  logic [NUM_SRC*stream_merge_pkg::WORD_W-1:0] src_data,
  output logic [NUM_SRC-1:0]                        src_ready,
  output logic                                      out_valid,
  output logic                                      out_last,
  output stream_merge_pkg::word_t                   out_data,
  input  logic                                      out_ready
);

  localparam int WORD_W = stream_merge_pkg::WORD_W;

  logic [NUM_SRC-1:0] grant;
  logic               granted_valid;
  logic               granted_last;
  logic               path_ready;

  // **************************************************
  // Grant control
  // **************************************************

  // Nothing moves until the host enables the merger
  assign path_ready = out_ready & enable;

  packet_granter #(
    .NUM_SRC(NUM_SRC)
  ) i_packet_granter (
    .clk          (clk),
    .rstnn        (rstnn),
    .clear        (clear),
    .enable       (enable),
    .cand_valid   (src_valid),
    .cand_hint    (src_hint),
    .cand_last    (src_last),
    .granted_ready(path_ready),
    .grant        (grant),
    .granted_valid(granted_valid),
    .granted_last (granted_last)
  );

  // Only the granted source sees ready
  assign src_ready = grant & {NUM_SRC{path_ready}};

  // **************************************************
  // Combinational output path
  // **************************************************

  // Valid is masked the same way as ready so both ends agree on a transfer
  assign out_valid = granted_valid & enable;
  assign out_last  = granted_last;

  // One-hot AND-OR select of the granted word
  always_comb
  begin
    out_data = '0;
    for (int i = 0; i < NUM_SRC; i++)
    begin
      out_data = out_data | (src_data[i*WORD_W +: WORD_W] & {WORD_W{grant[i]}});
    end
  end

endmodule

/* packet_fifo.sv */
/*
  Synchronous register-array FIFO of last flag and word entries
  Fill count output, same-cycle push and pop
*/

`timescale 1ns/1ps

module packet_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                            clk,
  input  logic                            rstnn,
  input  logic                            in_valid,
  input  logic                            in_last,
  input  stream_merge_pkg::word_t         in_data,
  output logic                            in_ready,
  output logic                            head_valid,
  output logic                            head_last,
  output stream_merge_pkg::word_t         head_data,
  output logic [$clog2(FIFO_DEPTH):0]     fill_count,
  input  logic                            pop
);

  localparam int ADDR_W  = $clog2(FIFO_DEPTH);
  // Entry is the last flag on top of the word
  localparam int ENTRY_W = 1 + stream_merge_pkg::WORD_W;
  localparam logic [ADDR_W:0] FULL_COUNT = (ADDR_W+1)'(FIFO_DEPTH);

  logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
  logic [ADDR_W-1:0]  wr_ptr;
  logic [ADDR_W-1:0]  rd_ptr;
  logic               push;
  logic               do_pop;

  // **************************************************
  // Flags and handshakes
  // **************************************************

  assign in_ready   = (fill_count != FULL_COUNT);
  assign head_valid = (fill_count != '0);

  assign push   = in_valid & in_ready;
  // Pop on an empty FIFO is dropped
  assign do_pop = pop & head_valid;

  // Head entry is shown straight from the array
  assign {head_last, head_data} = mem[rd_ptr];

  // **************************************************
  // Storage
  // **************************************************

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= {in_last, in_data};
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk or negedge rstnn)
  begin
    if (!rstnn)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill_count <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= wr_ptr + ADDR_W'(1);
      end
      if (do_pop)
      begin
        rd_ptr <= rd_ptr + ADDR_W'(1);
      end
      // Count holds when push and pop meet
      if (push && !do_pop)
      begin
        fill_count <= fill_count + (ADDR_W+1)'(1);
      end
      else if (!push && do_pop)
      begin
        fill_count <= fill_count - (ADDR_W+1)'(1);
      end
    end
  end

endmodule

/* apb_drain.sv */
/*
  Zero-wait APB slave that drains the packet FIFO
  DATA pop register, STATUS register, CTRL enable and clear
*/

`timescale 1ns/1ps

module apb_drain #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                          clk,
  input  logic                          rstnn,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  stream_merge_pkg::apb_addr_t   paddr,
  input  stream_merge_pkg::apb_data_t   pwdata,
  output stream_merge_pkg::apb_data_t   prdata,
  output logic                          pslverr,
  input  logic                          head_valid,
  input  logic                          head_last,
  input  stream_merge_pkg::word_t       head_data,
  input  logic [$clog2(FIFO_DEPTH):0]   fill_count,
  output logic                          pop,
  output logic                          enable,
  output logic                          clear
);

  // Fill count sits in bits 7:0 of STATUS
  localparam int FILL_W = $clog2(FIFO_DEPTH) + 1;

  logic access;
  logic hit_data;
  logic hit_status;
  logic hit_ctrl;
  logic ctrl_wr;

  // **************************************************
  // Address decode
  // **************************************************

  // Access phase completes in one cycle
  assign access = psel & penable;

  assign hit_data   = (paddr == stream_merge_pkg::REG_DATA);
  assign hit_status = (paddr == stream_merge_pkg::REG_STATUS);
  assign hit_ctrl   = (paddr == stream_merge_pkg::REG_CTRL);

  assign ctrl_wr = access & pwrite & hit_ctrl;

  // Read of DATA consumes the head word in the access cycle
  assign pop = access & ~pwrite & hit_data & head_valid;

  // **************************************************
  // Read data and error response
  // **************************************************

  always_comb
  begin
    prdata  = '0;
    pslverr = 1'b0;
    if (access)
    begin
      if (hit_data)
      begin
        // Write to DATA or read on empty FIFO is an error
        if (pwrite || !head_valid)
          pslverr = 1'b1;
        else
          prdata = stream_merge_pkg::apb_data_t'(head_data);
      end
      else if (hit_status)
      begin
        if (pwrite)
        begin
          pslverr = 1'b1;
        end
        else
        begin
          prdata[FILL_W-1:0] = fill_count;
          prdata[stream_merge_pkg::STATUS_LAST_BIT] = head_last;
        end
      end
      else if (hit_ctrl)
      begin
        if (!pwrite)
          prdata[stream_merge_pkg::CTRL_ENABLE_BIT] = enable;
      end
      else
      begin
        // Unmapped offset
        pslverr = 1'b1;
      end
    end
  end

  // **************************************************
  // Control register
  // **************************************************

  // Enable level and one-cycle clear pulse take effect after the access cycle
  always_ff @(posedge clk or negedge rstnn)
  begin
    if (!rstnn)
    begin
      enable <= 1'b0;
      clear  <= 1'b0;
    end
    else
    begin
      clear <= ctrl_wr & pwdata[stream_merge_pkg::CTRL_CLEAR_BIT];
      if (ctrl_wr)
      begin
        enable <= pwdata[stream_merge_pkg::CTRL_ENABLE_BIT];
      end
    end
  end

endmodule

/* stream_merge_top.sv */
/*
  Stream merge subsystem top level
  Merger, packet FIFO and APB drain
*/

`timescale 1ns/1ps

module stream_merge_top #(
  parameter int NUM_SRC    = 4,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                                        clk,
  input  logic                                        rstnn,
  input  logic [NUM_SRC-1:0]                          src_valid,
  input  logic [NUM_SRC-1:0]                          src_hint,
  input  logic [NUM_SRC-1:0]                          src_last,
  input  logic [NUM_SRC*stream_merge_pkg::WORD_W-1:0] src_data,
  output logic [NUM_SRC-1:0]                          src_ready,
  input  logic                                        psel,
  input  logic                                        penable,
  input  logic                                        pwrite,
  input  stream_merge_pkg::apb_addr_t                 paddr,
  input  stream_merge_pkg::apb_data_t                 pwdata,
  output stream_merge_pkg::apb_data_t                 prdata,
  output logic                                        pslverr
);

  // Merger to FIFO
  logic                    out_valid;
  logic                    out_last;
  stream_merge_pkg::word_t out_data;
  logic                    out_ready;

  // FIFO to drain
  logic                            head_valid;
  logic                            head_last;
  stream_merge_pkg::word_t         head_data;
  logic [$clog2(FIFO_DEPTH):0]     fill_count;
  logic                            pop;

  // Drain to merger
  logic enable;
  logic clear;

  stream_merger #(
    .NUM_SRC(NUM_SRC)
  ) i_stream_merger (
    .clk      (clk),
    .rstnn    (rstnn),
    .clear    (clear),
    .enable   (enable),
    .src_valid(src_valid),
    .src_hint (src_hint),
    .src_last (src_last),
    .src_data (src_data),
    .src_ready(src_ready),
    .out_valid(out_valid),
    .out_last (out_last),
    .out_data (out_data),
    .out_ready(out_ready)
  );

  packet_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) i_packet_fifo (
    .clk       (clk),
    .rstnn     (rstnn),
    .in_valid  (out_valid),
    .in_last   (out_last),
    .in_data   (out_data),
    .in_ready  (out_ready),
    .head_valid(head_valid),
    .head_last (head_last),
    .head_data (head_data),
    .fill_count(fill_count),
    .pop       (pop)
  );

  apb_drain #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) i_apb_drain (
    .clk       (clk),
    .rstnn     (rstnn),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pslverr   (pslverr),
    .head_valid(head_valid),
    .head_last (head_last),
    .head_data (head_data),
    .fill_count(fill_count),
    .pop       (pop),
    .enable    (enable),
    .clear     (clear)
  );

endmodule

/* stream_merge_assertions.sv */
/*
  Concurrent checks on the merger grant and source ready vector
  Bound into every stream_merger instance
*/

`timescale 1ns/1ps

module stream_merge_assertions #(
  parameter int NUM_SRC = 4
) (
  input logic               clk,
  input logic               rstnn,
  input logic               clear,
  input logic [NUM_SRC-1:0] grant,
  input logic [NUM_SRC-1:0] src_valid,
  input logic [NUM_SRC-1:0] src_ready,
  input logic               out_last
);

  // Count of failures that the testbench reads at the end of the run
  int error_count = 0;

  // Grant always names exactly one source
  a_grant_onehot: assert property (@(posedge clk) disable iff (!rstnn) $onehot(grant))
  else
  begin
    $error("Grant vector is not one-hot");
    error_count++;
  end

  // Packet lock holds the grant after a word that is not the last one
  a_grant_held: assert property (@(posedge clk) disable iff (!rstnn)
    ((|(src_valid & src_ready)) && !out_last && !clear) |=> $stable(grant))
  else
  begin
    $error("Grant moved inside a packet");
    error_count++;
  end

  // One source at most may see ready
  a_single_ready: assert property (@(posedge clk) disable iff (!rstnn) $onehot0(src_ready))
  else
  begin
    $error("More than one source ready bit is high");
    error_count++;
  end

endmodule

bind stream_merger stream_merge_assertions #(
  .NUM_SRC(NUM_SRC)
) i_stream_merge_assertions (
  .clk      (clk),
  .rstnn    (rstnn),
  .clear    (clear),
  .grant    (grant),
  .src_valid(src_valid),
  .src_ready(src_ready),
  .out_last (out_last)
);

/* tb_stream_merge.sv */
/*
  Directed testbench for the stream merge subsystem
  Clock, reset, LFSR, APB tasks, source drivers and the tests
*/

`timescale 1ns/1ps

module tb_stream_merge;

  localparam int NUM_SRC    = 4;
  localparam int FIFO_DEPTH = 8;
  localparam int WORD_W     = stream_merge_pkg::WORD_W;
  localparam int SRC_ID_W   = stream_merge_pkg::SRC_ID_W;
  localparam int SEQ_W      = WORD_W - SRC_ID_W;
  // Cycle limit of every wait loop
  localparam int TIMEOUT    = 400;

  logic                        clk;
  logic                        rstnn;
  logic [NUM_SRC-1:0]          src_valid;
  logic [NUM_SRC-1:0]          src_hint;
  logic [NUM_SRC-1:0]          src_last;
  logic [NUM_SRC*WORD_W-1:0]   src_data;
  logic [NUM_SRC-1:0]          src_ready;
  logic                        psel;
  logic                        penable;
  logic                        pwrite;
  stream_merge_pkg::apb_addr_t paddr;
  stream_merge_pkg::apb_data_t pwdata;
  stream_merge_pkg::apb_data_t prdata;
  logic                        pslverr;

  logic [31:0] lfsr_state = 32'h7b81;

  stream_merge_top #(
    .NUM_SRC   (NUM_SRC),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) i_stream_merge_top (
    .clk      (clk),
    .rstnn    (rstnn),
    .src_valid(src_valid),
    .src_hint (src_hint),
    .src_last (src_last),
    .src_data (src_data),
    .src_ready(src_ready),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pslverr  (pslverr)
  );

  // 8 ns clock
  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // **************************************************
  // Helpers
  // **************************************************

  // Galois LFSR with taps 32 22 2 1
  function automatic logic next_random_bit();
    logic bit_out;
    bit_out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (bit_out)
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    return bit_out;
  endfunction

  function automatic int random_value(input int nbits);
    int value;
    value = 0;
    for (int i = 0; i < nbits; i++)
      value = (value << 1) | int'(next_random_bit());
    return value;
  endfunction

  // Source index on top of the sequence number
  function automatic stream_merge_pkg::word_t make_word(input int src, input int seq);
    logic [SRC_ID_W-1:0] id;
    logic [SEQ_W-1:0]    num;
    id  = SRC_ID_W'(src);
    num = SEQ_W'(seq);
    return {id, num};
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic expect_eq(input int got, input int exp, input string what);
    assert (got == exp)
    else abort_run($sformatf("[FAIL] %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp));
  endtask

  // **************************************************
  // APB master
  // **************************************************

  task automatic apb_write(input stream_merge_pkg::apb_addr_t addr,
                           input stream_merge_pkg::apb_data_t data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    // Response is settled mid access cycle
    @(negedge clk);
    err = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input stream_merge_pkg::apb_addr_t addr,
                          output stream_merge_pkg::apb_data_t data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata;
    err  = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_ctrl(input logic en, input logic clr);
    stream_merge_pkg::apb_data_t data;
    logic                        err;
    data = '0;
    data[stream_merge_pkg::CTRL_ENABLE_BIT] = en;
    data[stream_merge_pkg::CTRL_CLEAR_BIT]  = clr;
    apb_write(stream_merge_pkg::REG_CTRL, data, err);
    expect_eq(err, 0, "pslverr on CTRL write");
  endtask

  task automatic read_status(output int fill, output logic last);
    stream_merge_pkg::apb_data_t data;
    logic                        err;
    apb_read(stream_merge_pkg::REG_STATUS, data, err);
    expect_eq(err, 0, "pslverr on STATUS read");
    fill = int'(data[7:0]);
    last = data[stream_merge_pkg::STATUS_LAST_BIT];
  endtask

  // Polls STATUS until the FIFO holds at least target words
  task automatic wait_for_fill(input int target, output logic last);
    int fill;
    int reads;
    reads = 0;
    read_status(fill, last);
    while (fill < target)
    begin
      if (reads == TIMEOUT)
        abort_run($sformatf("Timeout: FIFO fill level never reached %0d", target));
      reads++;
      read_status(fill, last);
    end
  endtask

  // Reads one packet and checks words and last flags
  task automatic drain_packet(input int src, input int len, input int seq_base);
    stream_merge_pkg::apb_data_t data;
    logic                        err;
    logic                        last;
    for (int w = 0; w < len; w++)
    begin
      wait_for_fill(1, last);
      expect_eq(last, (w == len - 1), "head last flag");
      apb_read(stream_merge_pkg::REG_DATA, data, err);
      expect_eq(err, 0, "pslverr on DATA read");
      expect_eq(int'(data), int'(make_word(src, seq_base + w)), "DATA word");
    end
  endtask

  task automatic wait_for_ready(input logic [NUM_SRC-1:0] pattern, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (src_ready !== pattern)
    begin
      if (cycles == TIMEOUT)
        abort_run($sformatf("Timeout: %s", what));
      cycles++;
      @(negedge clk);
    end
  endtask

  // **************************************************
  // Source driver
  // **************************************************

  // Holds each word until the merger takes it
  task automatic send_packet(input int src, input int len, input int seq_base);
    int cycles;
    for (int w = 0; w < len; w++)
    begin
      @(posedge clk);
      src_valid[src] <= 1'b1;
      src_last[src]  <= (w == len - 1);
      src_data[src*WORD_W +: WORD_W] <= make_word(src, seq_base + w);
      // Ready seen mid cycle means transfer on the next edge
      cycles = 0;
      @(negedge clk);
      while (!src_ready[src])
      begin
        if (cycles == TIMEOUT)
          abort_run($sformatf("Timeout: source %0d never got ready for word %0d", src, w));
        cycles++;
        @(negedge clk);
      end
    end
    @(posedge clk);
    src_valid[src] <= 1'b0;
    src_last[src]  <= 1'b0;
  endtask

  // **************************************************
  // Tests
  // **************************************************

  // Disabled after reset and then fixed priority 0 to 3
  task automatic enable_gate_and_priority();
    int                          len [NUM_SRC];
    int                          fill;
    logic                        last;
    logic                        err;
    stream_merge_pkg::apb_data_t data;
    for (int s = 0; s < NUM_SRC; s++)
      len[s] = random_value(2) + 1;
    fork
      send_packet(0, len[0], 'h100);
      send_packet(1, len[1], 'h110);
      send_packet(2, len[2], 'h120);
      send_packet(3, len[3], 'h130);
      begin
        repeat (12)
        begin
          @(negedge clk);
          expect_eq(src_ready, 0, "src_ready before enable");
        end
        read_status(fill, last);
        expect_eq(fill, 0, "fill level after reset");
        apb_read(stream_merge_pkg::REG_DATA, data, err);
        expect_eq(err, 1, "pslverr on empty DATA read");
        expect_eq(int'(data), 0, "prdata on empty DATA read");
        write_ctrl(1'b1, 1'b0);
        apb_read(stream_merge_pkg::REG_CTRL, data, err);
        expect_eq(err, 0, "pslverr on CTRL read");
        expect_eq(int'(data), 1, "CTRL read after enable");
        for (int s = 0; s < NUM_SRC; s++)
          drain_packet(s, len[s], 'h100 + 'h10 * s);
      end
    join
  endtask

  // Source 0 arrives while source 2 holds the grant
  task automatic merge_without_interleave();
    int len;
    int moved;
    int cycles;
    len = random_value(2) + 4;
    fork
      send_packet(2, len, 'h200);
      begin
        moved  = 0;
        cycles = 0;
        while (moved < len / 2)
        begin
          @(negedge clk);
          if (src_valid[2] && src_ready[2])
            moved++;
          if (cycles == TIMEOUT)
            abort_run("Timeout: source 2 packet did not get halfway");
          cycles++;
        end
        send_packet(0, 2, 'h280);
      end
      begin
        drain_packet(2, len, 'h200);
        drain_packet(0, 2, 'h280);
      end
    join
  endtask

  // FIFO fills up and back-pressure holds the sources
  task automatic fill_under_back_pressure();
    int   fill;
    logic last;
    fork
      send_packet(1, 12, 'h300);
      send_packet(3, 3, 'h340);
      begin
        wait_for_fill(FIFO_DEPTH, last);
        repeat (10) @(posedge clk);
        read_status(fill, last);
        expect_eq(fill, FIFO_DEPTH, "fill level while full");
        @(negedge clk);
        expect_eq(src_ready, 0, "src_ready while FIFO is full");
        drain_packet(1, 12, 'h300);
        drain_packet(3, 3, 'h340);
      end
    join
    read_status(fill, last);
    expect_eq(fill, 0, "fill level after drain");
  endtask

  // Hint moves the grant and clear brings it back to source 0
  task automatic hint_then_clear();
    stream_merge_pkg::apb_data_t data;
    logic                        err;
    write_ctrl(1'b1, 1'b1);
    wait_for_ready(4'b0001, "grant did not return to source 0 after clear");
    @(posedge clk);
    src_hint[3] <= 1'b1;
    wait_for_ready(4'b1000, "grant did not move to hinting source 3");
    @(posedge clk);
    src_hint[3] <= 1'b0;
    // Grant already sits on 3, so 3 goes first
    fork
      send_packet(3, 3, 'h400);
      send_packet(0, 2, 'h440);
      begin
        drain_packet(3, 3, 'h400);
        drain_packet(0, 2, 'h440);
      end
    join
    @(posedge clk);
    src_hint[3] <= 1'b1;
    wait_for_ready(4'b1000, "grant did not move back to hinting source 3");
    write_ctrl(1'b0, 1'b1);
    @(posedge clk);
    src_hint[3] <= 1'b0;
    @(negedge clk);
    expect_eq(src_ready, 0, "src_ready while disabled");
    fork
      send_packet(3, 2, 'h480);
      send_packet(0, 2, 'h4c0);
      begin
        repeat (4) @(posedge clk);
        write_ctrl(1'b1, 1'b0);
        drain_packet(0, 2, 'h4c0);
        drain_packet(3, 2, 'h480);
      end
    join
    // Error responses
    apb_read(4'hC, data, err);
    expect_eq(err, 1, "pslverr on unused offset");
    apb_write(stream_merge_pkg::REG_DATA, 32'h1234, err);
    expect_eq(err, 1, "pslverr on DATA write");
  endtask

  // **************************************************
  // Main sequence
  // **************************************************

  initial
  begin
    rstnn     <= 1'b0;
    src_valid <= '0;
    src_hint  <= '0;
    src_last  <= '0;
    src_data  <= '0;
    psel      <= 1'b0;
    penable   <= 1'b0;
    pwrite    <= 1'b0;
    paddr     <= '0;
    pwdata    <= '0;
    repeat (16) @(posedge clk);
    rstnn <= 1'b1;

    enable_gate_and_priority();
    merge_without_interleave();
    fill_under_back_pressure();
    hint_then_clear();

    repeat (4) @(posedge clk);
    if (i_stream_merge_top.i_stream_merger.i_stream_merge_assertions.error_count == 0)
    begin
      $display("NO ERRORS");
      $finish;
    end
    else
    begin
      $display("Concurrent assertions on the merger failed");
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped after assertion failures");
    end
  end

endmodule

/* stream_merge_top.f */
stream_merge_pkg.sv
packet_granter.sv
stream_merger.sv
packet_fifo.sv
apb_drain.sv
stream_merge_top.sv
stream_merge_assertions.sv
tb_stream_merge.sv

/* run.sh */
#!/bin/sh
# Builds the stream merge testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
    --top-module tb_stream_merge \
    -f stream_merge_top.f \
    -o sim_stream_merge; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_stream_merge 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
  exit 0
else
  echo "Pass line not found in simulation output"
  exit 1
fi
